/* Bender.yml */
package:
  name: rv_pipe_core

sources:
  - design/rv_isa_pkg.sv
  - design/pipe_pkg.sv
  - design/pipe_reg.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/mem_stage.sv
  - design/hazard_unit.sv
  - design/core.sv
  - target: simulation
    files:
      - bench/clk_gen.sv
      - bench/core_tb.sv

/* bench/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen #(
    parameter int period_ns = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

/* bench/core_tb.sv */
`timescale 1ns/1ns

module core_tb
    import rv_isa_pkg::*, pipe_pkg::*;
();

    localparam int clk_period   = 8;
    localparam int reset_cycles = 16;
    localparam int num_instrs   = 200;
    localparam int load_words   = num_instrs + 8;
    localparam int drain_cycles = 20;
    localparam int drive_delay  = 1;
    // Worst case six cycles per instruction
    localparam int run_cycles   = num_instrs * 6;
    // Run budget plus reset and program load, doubled
    localparam int timeout_ns   =
        2 * (run_cycles * clk_period + (reset_cycles + load_words) * clk_period);

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } retire_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } store_t;

    logic                       clk;
    logic                       rst_n;
    logic                       running;
    logic                       imem_we;
    logic [imem_words_log2-1:0] imem_addr;
    logic [xlen-1:0]            imem_data;
    logic                       retire_valid;
    logic [reg_addr_w-1:0]      retire_rd;
    logic [xlen-1:0]            retire_data;
    logic                       store_valid;
    logic [xlen-1:0]            store_addr;
    logic [xlen-1:0]            store_data;

    integer          seed = 32'h7363def6;
    logic [xlen-1:0] program_words [load_words];
    retire_t         retire_q[$];
    store_t          store_q[$];
    int              retire_count = 0;
    int              store_count = 0;
    logic            drained = 1'b0;

    clk_gen #(.period_ns(clk_period)) clk_gen_inst (.clk(clk));

    core core_inst (
        .clk(clk), .rst_n(rst_n), .running(running),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data),
        .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data)
    );

    // ====================
    // Helpers
    // ====================
    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped after error");
    endtask

    task automatic check_value(string name, logic [xlen-1:0] expected, logic [xlen-1:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure("trace value differs from the reference model");
        end
    endtask

    function automatic int random_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] encode_reg_op(logic [6:0] f7, logic [4:0] rs2,
                                                  logic [4:0] rs1, logic [2:0] f3,
                                                  logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opcode_op};
    endfunction

    function automatic logic [31:0] encode_imm_op(logic [11:0] imm, logic [4:0] rs1,
                                                  logic [2:0] f3, logic [4:0] rd,
                                                  logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] encode_store(logic [11:0] imm, logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, funct3_lw_sw, imm[4:0], opcode_store};
    endfunction

    // ====================
    // Program and model
    // ====================
    // Random program run in order on the model to fill both expected streams
    task automatic build_program();
        logic [xlen-1:0] model_regs [8];
        logic [xlen-1:0] model_mem [64];
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] value;
        logic [xlen-1:0] rnd;
        logic [11:0]     imm;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic            writes;
        int              kind;
        int              word;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < num_instrs; i++) begin
            kind   = random_below(9);
            rd     = random_below(8);
            rs1    = random_below(8);
            rs2    = random_below(8);
            rnd    = $random(seed);
            imm    = rnd[11:0];
            word   = random_below(64);
            a      = model_regs[rs1];
            b      = model_regs[rs2];
            writes = 1'b1;
            case (kind)
                0: begin
                    value = a + b;
                    program_words[i] = encode_reg_op(7'd0, rs2, rs1, funct3_add, rd);
                end
                1: begin
                    value = a - b;
                    program_words[i] = encode_reg_op(funct7_sub, rs2, rs1, funct3_add, rd);
                end
                2: begin
                    value = a & b;
                    program_words[i] = encode_reg_op(7'd0, rs2, rs1, funct3_and, rd);
                end
                3: begin
                    value = a | b;
                    program_words[i] = encode_reg_op(7'd0, rs2, rs1, funct3_or, rd);
                end
                4: begin
                    value = a ^ b;
                    program_words[i] = encode_reg_op(7'd0, rs2, rs1, funct3_xor, rd);
                end
                5: begin
                    value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    program_words[i] = encode_reg_op(7'd0, rs2, rs1, funct3_slt, rd);
                end
                6: begin
                    value = a + {{20{imm[11]}}, imm};
                    program_words[i] = encode_imm_op(imm, rs1, funct3_add, rd, opcode_op_imm);
                end
                7: begin
                    // Base register is always x0
                    value = model_mem[word];
                    program_words[i] = encode_imm_op(12'(word * 4), 5'd0, funct3_lw_sw, rd,
                                                     opcode_load);
                end
                default: begin
                    writes          = 1'b0;
                    model_mem[word] = b;
                    store_q.push_back('{addr: word * 4, data: b});
                    program_words[i] = encode_store(12'(word * 4), rs2);
                end
            endcase
            if (writes && rd != 5'd0) begin
                model_regs[rd] = value;
                retire_q.push_back('{rd: rd, data: value});
            end
        end
        for (int i = num_instrs; i < load_words; i++) begin
            program_words[i] = instr_nop;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < load_words; i++) begin
            @(posedge clk);
            #drive_delay;
            imem_we   = 1'b1;
            imem_addr = i;
            imem_data = program_words[i];
        end
        @(posedge clk);
        #drive_delay;
        imem_we = 1'b0;
    endtask

    // Runs with random halts until the drain is over
    task automatic toggle_running();
        int count;
        @(posedge clk);
        #drive_delay;
        running = 1'b1;
        count   = 4 + random_below(24);
        while (!drained) begin
            @(posedge clk);
            #drive_delay;
            if (count == 0) begin
                running = !running;
                count   = running ? 4 + random_below(24) : random_below(6);
            end else begin
                count--;
            end
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((retire_q.size() != 0 || store_q.size() != 0) && waited < run_cycles) begin
            @(posedge clk);
            waited++;
        end
        // Trailing nops must stay silent
        repeat (drain_cycles) @(posedge clk);
        drained = 1'b1;
    endtask

    // ====================
    // Trace monitor
    // ====================
    // Sampled mid-cycle while running and the stage registers are stable
    always @(negedge clk) begin : trace_monitor
        retire_t exp_retire;
        store_t  exp_store;
        if (!running && (retire_valid || store_valid)) begin
            stop_with_failure("trace strobe seen while running is low");
        end else begin
            if (retire_valid) begin
                if (retire_q.size() == 0) begin
                    stop_with_failure("retire reported with no retire left in the model");
                end else begin
                    exp_retire = retire_q.pop_front();
                    check_value($sformatf("retire %0d rd", retire_count),
                                exp_retire.rd, retire_rd);
                    check_value($sformatf("retire %0d data", retire_count),
                                exp_retire.data, retire_data);
                    retire_count++;
                end
            end
            if (store_valid) begin
                if (store_q.size() == 0) begin
                    stop_with_failure("store reported with no store left in the model");
                end else begin
                    exp_store = store_q.pop_front();
                    check_value($sformatf("store %0d addr", store_count),
                                exp_store.addr, store_addr);
                    check_value($sformatf("store %0d data", store_count),
                                exp_store.data, store_data);
                    store_count++;
                end
            end
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        stop_with_failure("watchdog timeout, the trace streams did not drain");
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        rst_n     = 1'b0;
        running   = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        build_program();
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        load_program();
        fork
            toggle_running();
            wait_for_drain();
        join
        if (retire_q.size() == 0 && store_q.size() == 0) begin
            $display("%0d retires and %0d stores matched", retire_count, store_count);
            $display("Simulation passed");
            $finish;
        end else begin
            stop_with_failure("expected trace entries were never reported");
        end
    end

endmodule

/* design/core.sv */
`timescale 1ns/1ns

module core
    import pipe_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       running,
    input  logic                       imem_we,
    input  logic [imem_words_log2-1:0] imem_addr,
    input  logic [xlen-1:0]            imem_data,
    output logic                       retire_valid,
    output logic [reg_addr_w-1:0]      retire_rd,
    output logic [xlen-1:0]            retire_data,
    output logic                       store_valid,
    output logic [xlen-1:0]            store_addr,
    output logic [xlen-1:0]            store_data
);

    logic                  if_valid, id_valid, ex_valid, mem_valid, wb_valid;
    logic [xlen-1:0]       if_instr, id_instr;
    id_ex_t                id_payload, ex_payload;
    ex_mem_t               ex_result, mem_payload;
    mem_wb_t               mem_result, wb_payload;
    logic [reg_addr_w-1:0] id_rs1, id_rs2;
    logic                  id_uses_rs2;
    logic                  load_stall;
    fwd_sel_t              fwd_a, fwd_b;

    // ====================
    // Fetch / decode
    // ====================
    fetch_stage fetch_inst (
        .clk(clk), .rst_n(rst_n), .running(running), .stall(load_stall),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
        .instr(if_instr), .instr_valid(if_valid)
    );

    pipe_reg #(.payload_t(logic [xlen-1:0])) if_id_inst (
        .clk(clk), .rst_n(rst_n), .running(running), .stall(load_stall), .bubble(1'b0),
        .in_valid(if_valid), .in_data(if_instr), .out_valid(id_valid), .out_data(id_instr)
    );

    decode_stage decode_inst (
        .clk(clk), .rst_n(rst_n), .in_valid(id_valid), .instr(id_instr),
        .wb_valid(wb_valid), .wb(wb_payload), .rs1(id_rs1), .rs2(id_rs2),
        .uses_rs2(id_uses_rs2), .payload(id_payload)
    );

    // ====================
    // Execute / memory
    // ====================
    pipe_reg #(.payload_t(id_ex_t)) id_ex_inst (
        .clk(clk), .rst_n(rst_n), .running(running), .stall(1'b0), .bubble(load_stall),
        .in_valid(id_valid), .in_data(id_payload), .out_valid(ex_valid), .out_data(ex_payload)
    );

    execute_stage execute_inst (
        .in(ex_payload), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_bypass(mem_payload.alu_result), .wb_bypass(wb_payload), .out(ex_result)
    );

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_inst (
        .clk(clk), .rst_n(rst_n), .running(running), .stall(1'b0), .bubble(1'b0),
        .in_valid(ex_valid), .in_data(ex_result), .out_valid(mem_valid), .out_data(mem_payload)
    );

    mem_stage mem_inst (
        .clk(clk), .running(running), .in_valid(mem_valid), .in(mem_payload),
        .out(mem_result), .store_valid(store_valid), .store_addr(store_addr),
        .store_data(store_data)
    );

    // ====================
    // Writeback / hazards
    // ====================
    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_inst (
        .clk(clk), .rst_n(rst_n), .running(running), .stall(1'b0), .bubble(1'b0),
        .in_valid(mem_valid), .in_data(mem_result), .out_valid(wb_valid), .out_data(wb_payload)
    );

    hazard_unit hazard_inst (
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_uses_rs2(id_uses_rs2),
        .ex_valid(ex_valid), .ex(ex_payload), .mem_valid(mem_valid), .mem(mem_payload),
        .wb_valid(wb_valid), .wb(wb_payload),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .load_stall(load_stall)
    );

    // Retire trace, quiet while halted
    assign retire_valid = running && wb_valid && wb_payload.reg_write;
    assign retire_rd    = wb_payload.rd;
    assign retire_data  = wb_payload.result;

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [xlen-1:0]       instr,
    input  logic                  wb_valid,
    input  mem_wb_t               wb,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic                  uses_rs2,
    output id_ex_t                payload
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    logic                  wb_write;
    ctrl_t                 ctrl;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       regs [2**reg_addr_w];

    function automatic alu_op_t alu_sel(logic [2:0] f3, logic sub);
        case (f3)
            funct3_add: return sub ? alu_sub : alu_add;
            funct3_slt: return alu_slt;
            funct3_xor: return alu_xor;
            funct3_or:  return alu_or;
            funct3_and: return alu_and;
            default:    return alu_add;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = in_valid ? instr[19:15] : '0;
    assign rs2    = in_valid ? instr[24:20] : '0;

    // ====================
    // Decoder
    // ====================
    always_comb begin
        ctrl     = '0;
        uses_rs2 = 1'b0;
        imm      = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            opcode_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_sel(funct3, funct7 == funct7_sub);
                uses_rs2       = 1'b1;
            end
            opcode_op_imm: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_use_imm = 1'b1;
                ctrl.alu_op      = alu_sel(funct3, 1'b0);
            end
            opcode_load: begin
                ctrl.reg_write   = funct3 == funct3_lw_sw;
                ctrl.mem_read    = funct3 == funct3_lw_sw;
                ctrl.alu_use_imm = 1'b1;
            end
            opcode_store: begin
                ctrl.mem_write   = funct3 == funct3_lw_sw;
                ctrl.alu_use_imm = 1'b1;
                uses_rs2         = 1'b1;
                imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            default: ;
        endcase
        // x0 is never a destination
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
        if (!in_valid) begin
            ctrl     = '0;
            uses_rs2 = 1'b0;
        end
    end

    // ====================
    // Register file
    // ====================
    assign wb_write = wb_valid && wb.reg_write && wb.rd != '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Write-through from writeback
    assign payload.rs1_data = (wb_write && wb.rd == rs1) ? wb.result : regs[rs1];
    assign payload.rs2_data = (wb_write && wb.rd == rs2) ? wb.result : regs[rs2];
    assign payload.ctrl     = ctrl;
    assign payload.rs1      = rs1;
    assign payload.rs2      = rs2;
    assign payload.rd       = rd;
    assign payload.imm      = imm;

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  id_ex_t          in,
    input  fwd_sel_t        fwd_a,
    input  fwd_sel_t        fwd_b,
    input  logic [xlen-1:0] mem_bypass,
    input  mem_wb_t         wb_bypass,
    output ex_mem_t         out
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;

    function automatic logic [xlen-1:0] pick(fwd_sel_t sel, logic [xlen-1:0] reg_val,
                                             logic [xlen-1:0] mem_val,
                                             logic [xlen-1:0] wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // Forwarding muxes
    assign op_a    = pick(fwd_a, in.rs1_data, mem_bypass, wb_bypass.result);
    assign rs2_val = pick(fwd_b, in.rs2_data, mem_bypass, wb_bypass.result);
    assign op_b    = in.ctrl.alu_use_imm ? in.imm : rs2_val;

    // ALU
    always_comb begin
        case (in.ctrl.alu_op)
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_xor: result = op_a ^ op_b;
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: result = op_a + op_b;
        endcase
    end

    assign out.reg_write  = in.ctrl.reg_write;
    assign out.mem_read   = in.ctrl.mem_read;
    assign out.mem_write  = in.ctrl.mem_write;
    assign out.rd         = in.rd;
    assign out.alu_result = result;
    // Store data takes the forwarded rs2
    assign out.store_data = rs2_val;

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       running,
    input  logic                       stall,
    input  logic                       imem_we,
    input  logic [imem_words_log2-1:0] imem_addr,
    input  logic [xlen-1:0]            imem_data,
    output logic [xlen-1:0]            instr,
    output logic                       instr_valid
);

    // Byte address, wraps with the memory size
    logic [imem_words_log2+1:0] pc;

    // Empty words read as nop
    logic [xlen-1:0] imem [2**imem_words_log2] = '{default: instr_nop};

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= '0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b1;
            if (running && !stall) begin
                pc <= pc + 4;
            end
        end
    end

    assign instr = imem[pc[imem_words_log2+1:2]];

    // Program loads only while the core is halted
    a_load_halted: assert property (@(posedge clk) disable iff (!rst_n)
        !(imem_we && running))
        else $error("fetch_stage: imem write while running");

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit
    import pipe_pkg::*;
(
    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,
    input  logic                  id_uses_rs2,
    input  logic                  ex_valid,
    input  id_ex_t                ex,
    input  logic                  mem_valid,
    input  ex_mem_t               mem,
    input  logic                  wb_valid,
    input  mem_wb_t               wb,
    output fwd_sel_t              fwd_a,
    output fwd_sel_t              fwd_b,
    output logic                  load_stall
);

    logic mem_fwd_ok;
    logic wb_fwd_ok;

    assign mem_fwd_ok = mem_valid && mem.reg_write && mem.rd != '0;
    assign wb_fwd_ok  = wb_valid && wb.reg_write && wb.rd != '0;

    // Younger result wins
    function automatic fwd_sel_t fwd_pick(logic [reg_addr_w-1:0] rs, logic mem_ok,
                                          logic [reg_addr_w-1:0] mem_rd, logic wb_ok,
                                          logic [reg_addr_w-1:0] wb_rd);
        if (mem_ok && mem_rd == rs) return fwd_mem;
        if (wb_ok && wb_rd == rs) return fwd_wb;
        return fwd_none;
    endfunction

    assign fwd_a = fwd_pick(ex.rs1, mem_fwd_ok, mem.rd, wb_fwd_ok, wb.rd);
    assign fwd_b = fwd_pick(ex.rs2, mem_fwd_ok, mem.rd, wb_fwd_ok, wb.rd);

    // Load result not ready until writeback
    assign load_stall = ex_valid && ex.ctrl.mem_read && ex.ctrl.reg_write &&
                        (ex.rd == id_rs1 || (id_uses_rs2 && ex.rd == id_rs2));

    // The stall must keep load data off the memory-stage bypass
    // Only operands that a valid instruction actually uses count here
    always_comb begin
        if (ex_valid && (fwd_a == fwd_mem ||
                (fwd_b == fwd_mem && (!ex.ctrl.alu_use_imm || ex.ctrl.mem_write)))) begin
            a_no_load_fwd: assert final (!mem.mem_read)
                else $error("hazard_unit: load forwarded from memory stage");
        end
    end

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            running,
    input  logic            in_valid,
    input  ex_mem_t         in,
    output mem_wb_t         out,
    output logic            store_valid,
    output logic [xlen-1:0] store_addr,
    output logic [xlen-1:0] store_data
);

    logic [xlen-1:0] dmem [2**dmem_words_log2] = '{default: '0};
    logic [xlen-1:0] load_word;

    // Word index from address bits 9:2
    assign load_word = dmem[in.alu_result[dmem_words_log2+1:2]];

    always_ff @(posedge clk) begin
        if (store_valid) begin
            dmem[in.alu_result[dmem_words_log2+1:2]] <= in.store_data;
        end
    end

    assign store_valid = running && in_valid && in.mem_write;
    assign store_addr  = in.alu_result;
    assign store_data  = in.store_data;

    assign out.reg_write = in.reg_write;
    assign out.rd        = in.rd;
    assign out.result    = in.mem_read ? load_word : in.alu_result;

    // Only whole-word accesses
    a_aligned: assert property (@(posedge clk)
        (in_valid && (in.mem_read || in.mem_write)) |-> in.alu_result[1:0] == 2'b00)
        else $error("mem_stage: misaligned access at %h", in.alu_result);

endmodule

/* design/pipe_pkg.sv */
package pipe_pkg;

    import rv_isa_pkg::*;

    // ====================
    // Sizes
    // ====================
    localparam int xlen            = 32;
    localparam int reg_addr_w      = 5;
    localparam int imem_words_log2 = 8;
    localparam int dmem_words_log2 = 8;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // ====================
    // Stage payloads
    // ====================
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_use_imm;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } mem_wb_t;

endpackage

/* design/pipe_reg.sv */
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     running,
    input  logic     stall,
    input  logic     bubble,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (running && !stall) begin
            out_valid <= bubble ? 1'b0 : in_valid;
        end
    end

    // Payload follows valid, contents ignored when invalid
    always_ff @(posedge clk) begin
        if (running && !stall) begin
            out_data <= in_data;
        end
    end

    // Hazard logic must not hold and flush the same register
    a_no_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        !(stall && bubble))
        else $error("pipe_reg: stall and bubble together");

endmodule

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ====================
    // Opcodes
    // ====================
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;

    // ====================
    // Function fields
    // ====================
    localparam logic [2:0] funct3_add   = 3'b000;
    localparam logic [2:0] funct3_slt   = 3'b010;
    localparam logic [2:0] funct3_xor   = 3'b100;
    localparam logic [2:0] funct3_or    = 3'b110;
    localparam logic [2:0] funct3_and   = 3'b111;
    localparam logic [2:0] funct3_lw_sw = 3'b010;

    // Only funct7 value that changes an operation here
    localparam logic [6:0] funct7_sub = 7'b0100000;

    // ALU operations
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

    // addi x0, x0, 0
    localparam logic [31:0] instr_nop = 32'h0000_0013;

endpackage

/* filelist.f */
design/rv_isa_pkg.sv
design/pipe_pkg.sv
design/pipe_reg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/hazard_unit.sv
design/core.sv
bench/clk_gen.sv
bench/core_tb.sv
